// ==== common/segxbar_pkg.sv ====
package segxbar_pkg;

    // ========================================
    // Gear encodings
    // ========================================

    // LMT width in PMTs is 2**width_gear
    // 0 gives one PMT per row, 1 gives two
    typedef logic width_gear_t;

    // LMT depth in PMT rows is 2**depth_gear, so 1 to 8 rows
    typedef logic [1:0] depth_gear_t;

    // ========================================
    // Pool sizing
    // ========================================

    // Bits held by one PMT entry, which is also the segment width
    localparam int DEF_PMT_WIDTH = 16;

    // Entries in one PMT
    localparam int DEF_PMT_DEPTH = 16;

    // Physical match tables in the pool
    localparam int DEF_NUM_PMTS = 8;

    // Widest LMT the crossbar can build, in PMTs
    // Sets the LMT key and entry width at the top level
    localparam int MAX_WIDTH_BLOCKS = 2;

endpackage

// ==== common/pmt_bus_if.sv ====
`timescale 1ns/1ps

interface pmt_bus_if #(
    parameter int NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS,
    parameter int PMT_WIDTH = segxbar_pkg::DEF_PMT_WIDTH,
    parameter int PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH
);

    localparam int PMT_AW = $clog2(PMT_DEPTH);

    // Write side, one enable and one segment per PMT
    logic [NUM_PMTS-1:0]                wr_en;
    logic [PMT_AW-1:0]                  wr_addr;
    logic [NUM_PMTS-1:0][PMT_WIDTH-1:0] wr_data;
    logic [NUM_PMTS-1:0][PMT_WIDTH-1:0] wr_mask;

    // Drops every entry valid bit
    logic                               clear;

    // Search side
    logic                               search_en;
    logic [NUM_PMTS-1:0][PMT_WIDTH-1:0] search_key;

    // One bit per entry, registered in the pool
    logic [NUM_PMTS-1:0][PMT_DEPTH-1:0] matchlines;

    modport xbar (
        output wr_en, wr_addr, wr_data, wr_mask,
        output clear,
        output search_en, search_key,
        input  matchlines
    );

    modport pool (
        input  wr_en, wr_addr, wr_data, wr_mask,
        input  clear,
        input  search_en, search_key,
        output matchlines
    );

endinterface

// ==== crossbar/gear_config.sv ====
`timescale 1ns/1ps

module gear_config #(
    parameter int NUM_PMTS = segxbar_pkg::DEF_NUM_PMTS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_load,
    input  segxbar_pkg::width_gear_t  cfg_width_gear,
    input  segxbar_pkg::depth_gear_t  cfg_depth_gear,
    output segxbar_pkg::width_gear_t  width_gear,
    output segxbar_pkg::depth_gear_t  depth_gear,
    output logic                      cfg_error,
    output logic [NUM_PMTS-1:0]       pmt_active,
    output logic                      cfg_clear
);

    int   req_cnt;
    int   active_cnt;
    logic cfg_ok;

    // PMTs the requested shape would need
    assign req_cnt = (int'(1) << cfg_width_gear) * (int'(1) << cfg_depth_gear);
    assign cfg_ok  = (req_cnt <= NUM_PMTS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            width_gear <= '0;
            depth_gear <= '0;
            cfg_error  <= 1'b0;
            cfg_clear  <= 1'b0;
        end else begin
            cfg_clear <= 1'b0;
            if (cfg_load) begin
                if (cfg_ok) begin
                    width_gear <= cfg_width_gear;
                    depth_gear <= cfg_depth_gear;
                    cfg_error  <= 1'b0;
                    cfg_clear  <= 1'b1;
                end else begin
                    // Old gears stay in force
                    cfg_error <= 1'b1;
                end
            end
        end
    end

    // The single LMT owns PMTs from index 0 upward
    assign active_cnt = (int'(1) << width_gear) * (int'(1) << depth_gear);

    always_comb begin
        for (int i = 0; i < NUM_PMTS; i++) begin
            pmt_active[i] = (i < active_cnt);
        end
    end

    a_active_fits : assert property (@(posedge clk) disable iff (!rst_n)
        active_cnt <= NUM_PMTS);

endmodule

// ==== crossbar/xbar_fanout.sv ====
`timescale 1ns/1ps

module xbar_fanout #(
    parameter int   PMT_WIDTH = segxbar_pkg::DEF_PMT_WIDTH,
    parameter int   PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH,
    parameter int   NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS,
    localparam int  LMT_KEY_W = segxbar_pkg::MAX_WIDTH_BLOCKS * PMT_WIDTH,
    localparam int  LMT_AW    = $clog2(PMT_DEPTH * NUM_PMTS)
) (
    input  segxbar_pkg::width_gear_t  width_gear,
    input  logic [NUM_PMTS-1:0]       pmt_active,
    input  logic                      cfg_clear,
    input  logic                      wr_en,
    input  logic [LMT_AW-1:0]         wr_addr,
    input  logic [LMT_KEY_W-1:0]      wr_data,
    input  logic [LMT_KEY_W-1:0]      wr_mask,
    input  logic                      search_en,
    input  logic [LMT_KEY_W-1:0]      search_key,
    pmt_bus_if.xbar                   bus
);

    localparam int PMT_AW = $clog2(PMT_DEPTH);
    localparam int ROW_W  = LMT_AW - PMT_AW;

    int               width_blocks;
    int               depth_blocks;
    logic [ROW_W-1:0] wr_row;

    assign width_blocks = int'(1) << width_gear;
    assign depth_blocks = $countones(pmt_active) >> width_gear;

    // ========================================
    // SELECT
    // ========================================

    // Upper bits pick the PMT row, lower bits the entry inside it
    assign wr_row      = wr_addr[LMT_AW-1:PMT_AW];
    assign bus.wr_addr = wr_addr[PMT_AW-1:0];

    assign bus.clear     = cfg_clear;
    assign bus.search_en = search_en;

    // ========================================
    // PARTITION and SPREAD
    // ========================================

    always_comb begin
        int col;
        int row;
        for (int i = 0; i < NUM_PMTS; i++) begin
            // PMT i sits at row i / width_blocks, column i % width_blocks
            col = i & (width_blocks - 1);
            row = i >> width_gear;

            bus.wr_en[i]   = wr_en && pmt_active[i] && (row == int'(wr_row));
            bus.wr_data[i] = wr_data[col*PMT_WIDTH +: PMT_WIDTH];
            bus.wr_mask[i] = wr_mask[col*PMT_WIDTH +: PMT_WIDTH];

            // Key goes to every active PMT, sliced by column
            if (pmt_active[i]) begin
                bus.search_key[i] = search_key[col*PMT_WIDTH +: PMT_WIDTH];
            end else begin
                bus.search_key[i] = '0;
            end
        end
    end

    // A write inside the LMT depth lands on a full row, one PMT per column
    always_comb begin
        if (wr_en && (int'(wr_row) < depth_blocks)) begin
            a_one_per_block : assert final ($countones(bus.wr_en) == width_blocks)
                else $error("xbar_fanout: %0d PMTs enabled, expected %0d",
                            $countones(bus.wr_en), width_blocks);
        end
    end

endmodule

// ==== crossbar/match_combine.sv ====
`timescale 1ns/1ps

module match_combine #(
    parameter int   PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH,
    parameter int   NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS,
    localparam int  LMT_AW    = $clog2(PMT_DEPTH * NUM_PMTS)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  segxbar_pkg::width_gear_t  width_gear,
    input  segxbar_pkg::depth_gear_t  depth_gear,
    input  logic                      search_en,
    pmt_bus_if.xbar                   bus,
    output logic                      match_valid,
    output logic                      match_found,
    output logic [LMT_AW-1:0]         match_addr
);

    localparam int LMT_ENTRIES = PMT_DEPTH * NUM_PMTS;
    localparam int MAX_WB      = segxbar_pkg::MAX_WIDTH_BLOCKS;

    int                     width_blocks;
    int                     depth_blocks;
    logic [LMT_ENTRIES-1:0] lmt_ml;
    logic [LMT_AW-1:0]      first_addr;
    logic                   search_d1;

    assign width_blocks = int'(1) << width_gear;
    assign depth_blocks = int'(1) << depth_gear;

    // ========================================
    // MAND and COMBINE
    // ========================================

    // Row r of the LMT covers addresses r*PMT_DEPTH upward
    always_comb begin
        int   idx;
        logic hit;
        lmt_ml = '0;
        for (int r = 0; r < NUM_PMTS; r++) begin
            for (int e = 0; e < PMT_DEPTH; e++) begin
                hit = (r < depth_blocks);
                // Every column of the row must agree
                for (int k = 0; k < MAX_WB; k++) begin
                    idx = r * width_blocks + k;
                    if (k < width_blocks) begin
                        if (idx < NUM_PMTS) begin
                            hit = hit & bus.matchlines[idx][e];
                        end else begin
                            hit = 1'b0;
                        end
                    end
                end
                lmt_ml[r*PMT_DEPTH + e] = hit;
            end
        end
    end

    // Lowest address wins
    always_comb begin
        first_addr = '0;
        for (int a = LMT_ENTRIES - 1; a >= 0; a--) begin
            if (lmt_ml[a]) begin
                first_addr = LMT_AW'(a);
            end
        end
    end

    // ========================================
    // Result registers
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            search_d1   <= 1'b0;
            match_valid <= 1'b0;
            match_found <= 1'b0;
        end else begin
            search_d1   <= search_en;
            match_valid <= search_d1;
            match_found <= search_d1 && (|lmt_ml);
        end
    end

    always_ff @(posedge clk) begin
        if (search_d1) begin
            match_addr <= first_addr;
        end
    end

    a_found_needs_valid : assert property (@(posedge clk) disable iff (!rst_n)
        match_found |-> match_valid);

    // Gears must hold while a search is between the pool and this stage
    a_no_reconfig_in_flight : assert property (@(posedge clk) disable iff (!rst_n)
        search_en |=> ($stable(width_gear) && $stable(depth_gear)));

endmodule

// ==== pool/pmt_tcam_array.sv ====
`timescale 1ns/1ps

module pmt_tcam_array #(
    parameter int PMT_WIDTH = segxbar_pkg::DEF_PMT_WIDTH,
    parameter int PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH,
    parameter int NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS
) (
    input  logic     clk,
    input  logic     rst_n,
    pmt_bus_if.pool  bus
);

    // Entry storage, one data and one care mask per entry
    logic [PMT_WIDTH-1:0]               data_mem [NUM_PMTS][PMT_DEPTH];
    logic [PMT_WIDTH-1:0]               mask_mem [NUM_PMTS][PMT_DEPTH];
    logic [NUM_PMTS-1:0][PMT_DEPTH-1:0] entry_valid;

    // ========================================
    // Write and clear
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (bus.clear) begin
            entry_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_PMTS; p++) begin
                if (bus.wr_en[p]) begin
                    entry_valid[p][bus.wr_addr] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PMTS; p++) begin
            if (bus.wr_en[p]) begin
                data_mem[p][bus.wr_addr] <= bus.wr_data[p];
                mask_mem[p][bus.wr_addr] <= bus.wr_mask[p];
            end
        end
    end

    // ========================================
    // Ternary compare
    // ========================================

    // Mask bit 1 means the bit takes part in the compare
    // Matchlines hold their last value between searches
    always_ff @(posedge clk) begin
        if (bus.search_en) begin
            for (int p = 0; p < NUM_PMTS; p++) begin
                for (int e = 0; e < PMT_DEPTH; e++) begin
                    bus.matchlines[p][e] <= entry_valid[p][e] &&
                        (((data_mem[p][e] ^ bus.search_key[p]) & mask_mem[p][e]) == '0);
                end
            end
        end
    end

    a_clear_no_write : assert property (@(posedge clk) disable iff (!rst_n)
        bus.clear |-> (bus.wr_en == '0));

endmodule

// ==== src/seg_tcam_top.sv ====
`timescale 1ns/1ps

module seg_tcam_top #(
    parameter int   PMT_WIDTH = segxbar_pkg::DEF_PMT_WIDTH,
    parameter int   PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH,
    parameter int   NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS,
    localparam int  LMT_KEY_W = segxbar_pkg::MAX_WIDTH_BLOCKS * PMT_WIDTH,
    localparam int  LMT_AW    = $clog2(PMT_DEPTH * NUM_PMTS)
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // Gear configuration
    input  logic                      cfg_load,
    input  segxbar_pkg::width_gear_t  cfg_width_gear,
    input  segxbar_pkg::depth_gear_t  cfg_depth_gear,
    output logic                      cfg_error,
    output segxbar_pkg::width_gear_t  width_gear,
    output segxbar_pkg::depth_gear_t  depth_gear,

    // LMT entry write
    input  logic                      wr_en,
    input  logic [LMT_AW-1:0]         wr_addr,
    input  logic [LMT_KEY_W-1:0]      wr_data,
    input  logic [LMT_KEY_W-1:0]      wr_mask,

    // LMT search, result two cycles after the strobe
    input  logic                      search_en,
    input  logic [LMT_KEY_W-1:0]      search_key,
    output logic                      match_valid,
    output logic                      match_found,
    output logic [LMT_AW-1:0]         match_addr
);

    logic [NUM_PMTS-1:0] pmt_active;
    logic                cfg_clear;

    pmt_bus_if #(
        .NUM_PMTS  (NUM_PMTS),
        .PMT_WIDTH (PMT_WIDTH),
        .PMT_DEPTH (PMT_DEPTH)
    ) bus ();

    gear_config #(
        .NUM_PMTS (NUM_PMTS)
    ) u_gear_config (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_load       (cfg_load),
        .cfg_width_gear (cfg_width_gear),
        .cfg_depth_gear (cfg_depth_gear),
        .width_gear     (width_gear),
        .depth_gear     (depth_gear),
        .cfg_error      (cfg_error),
        .pmt_active     (pmt_active),
        .cfg_clear      (cfg_clear)
    );

    // LMT side onto the PMT bus
    xbar_fanout #(
        .PMT_WIDTH (PMT_WIDTH),
        .PMT_DEPTH (PMT_DEPTH),
        .NUM_PMTS  (NUM_PMTS)
    ) u_xbar_fanout (
        .width_gear (width_gear),
        .pmt_active (pmt_active),
        .cfg_clear  (cfg_clear),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_mask    (wr_mask),
        .search_en  (search_en),
        .search_key (search_key),
        .bus        (bus.xbar)
    );

    pmt_tcam_array #(
        .PMT_WIDTH (PMT_WIDTH),
        .PMT_DEPTH (PMT_DEPTH),
        .NUM_PMTS  (NUM_PMTS)
    ) u_pmt_tcam_array (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.pool)
    );

    // Matchlines back to one LMT result
    match_combine #(
        .PMT_DEPTH (PMT_DEPTH),
        .NUM_PMTS  (NUM_PMTS)
    ) u_match_combine (
        .clk         (clk),
        .rst_n       (rst_n),
        .width_gear  (width_gear),
        .depth_gear  (depth_gear),
        .search_en   (search_en),
        .bus         (bus.xbar),
        .match_valid (match_valid),
        .match_found (match_found),
        .match_addr  (match_addr)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release just after an edge so no flop sees it at the same time
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== bench/tb_seg_tcam.sv ====
`timescale 1ns/1ps

module tb_seg_tcam;

    localparam int PMT_WIDTH = segxbar_pkg::DEF_PMT_WIDTH;
    localparam int PMT_DEPTH = segxbar_pkg::DEF_PMT_DEPTH;
    localparam int NUM_PMTS  = segxbar_pkg::DEF_NUM_PMTS;
    localparam int KEY_W     = segxbar_pkg::MAX_WIDTH_BLOCKS * PMT_WIDTH;
    localparam int AW        = $clog2(PMT_DEPTH * NUM_PMTS);
    localparam int ENTRIES   = PMT_DEPTH * NUM_PMTS;

    // Rough test lengths in cycles, the watchdog adds them up
    localparam int WATCHDOG_CYCLES = 20 + 40 + 120 + 60 + 60 + 100;

    logic                     clk;
    logic                     rst_n;
    logic                     cfg_load;
    segxbar_pkg::width_gear_t cfg_width_gear;
    segxbar_pkg::depth_gear_t cfg_depth_gear;
    logic                     cfg_error;
    segxbar_pkg::width_gear_t width_gear;
    segxbar_pkg::depth_gear_t depth_gear;
    logic                     wr_en;
    logic [AW-1:0]            wr_addr;
    logic [KEY_W-1:0]         wr_data;
    logic [KEY_W-1:0]         wr_mask;
    logic                     search_en;
    logic [KEY_W-1:0]         search_key;
    logic                     match_valid;
    logic                     match_found;
    logic [AW-1:0]            match_addr;

    // Reference copy of the LMT
    logic [KEY_W-1:0] ref_data  [ENTRIES];
    logic [KEY_W-1:0] ref_mask  [ENTRIES];
    logic             ref_valid [ENTRIES];
    logic             ref_wgear;
    logic [1:0]       ref_dgear;
    logic             ref_err;

    // Expected search results, oldest first
    logic          exp_found_q [$];
    logic [AW-1:0] exp_addr_q  [$];
    int            exp_due_q   [$];

    integer        seed = 49123;
    int            cyc;
    int            err_count;
    int            check_count;
    logic          cmp_found;
    logic [AW-1:0] cmp_addr;
    int            cmp_due;

    tb_clock_gen #(.HALF_PERIOD_NS(5), .RESET_CYCLES(4)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    seg_tcam_top #(
        .PMT_WIDTH (PMT_WIDTH),
        .PMT_DEPTH (PMT_DEPTH),
        .NUM_PMTS  (NUM_PMTS)
    ) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_load       (cfg_load),
        .cfg_width_gear (cfg_width_gear),
        .cfg_depth_gear (cfg_depth_gear),
        .cfg_error      (cfg_error),
        .width_gear     (width_gear),
        .depth_gear     (depth_gear),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_mask        (wr_mask),
        .search_en      (search_en),
        .search_key     (search_key),
        .match_valid    (match_valid),
        .match_found    (match_found),
        .match_addr     (match_addr)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ========================================
    // Reference model
    // ========================================

    // Lowest valid entry inside the active depth whose compared bits equal the key
    function automatic logic [AW:0] expected_result(input logic [KEY_W-1:0] key);
        logic [KEY_W-1:0] cmp_bits;
        int               rows;
        cmp_bits = {{PMT_WIDTH{ref_wgear}}, {PMT_WIDTH{1'b1}}};
        rows     = 1 << ref_dgear;
        for (int a = 0; a < ENTRIES; a++) begin
            if (ref_valid[a] && (a / PMT_DEPTH < rows) &&
                    (((ref_data[a] ^ key) & ref_mask[a] & cmp_bits) == '0)) begin
                return {1'b1, AW'(a)};
            end
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_count++;
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("Error at cycle %0d: %s", cyc, msg);
    endtask

    // ========================================
    // Drivers
    // ========================================

    task automatic step();
        @(posedge clk);
        #1;
        cfg_load  = 1'b0;
        wr_en     = 1'b0;
        search_en = 1'b0;
    endtask

    // Expected result is taken before any write in the same cycle lands
    task automatic start_search(input logic [KEY_W-1:0] key);
        logic [AW:0] res;
        res = expected_result(key);
        exp_found_q.push_back(res[AW]);
        exp_addr_q.push_back(res[AW-1:0]);
        exp_due_q.push_back(cyc + 2);
        search_en  = 1'b1;
        search_key = key;
    endtask

    task automatic start_write(input logic [AW-1:0] addr, input logic [KEY_W-1:0] data,
                               input logic [KEY_W-1:0] mask);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        wr_mask = mask;
        // Rows past the active depth write nothing
        if (int'(addr) / PMT_DEPTH < (1 << ref_dgear)) begin
            ref_data[addr]  = data;
            ref_mask[addr]  = mask;
            ref_valid[addr] = 1'b1;
        end
    endtask

    task automatic do_search(input logic [KEY_W-1:0] key);
        start_search(key);
        step();
    endtask

    task automatic do_write(input logic [AW-1:0] addr, input logic [KEY_W-1:0] data,
                            input logic [KEY_W-1:0] mask);
        start_write(addr, data, mask);
        step();
    endtask

    task automatic check_gears();
        check_count += 3;
        assert (cfg_error == ref_err) else report_mismatch("cfg_error", cfg_error, ref_err);
        assert (width_gear == ref_wgear) else report_mismatch("width_gear", width_gear, ref_wgear);
        assert (depth_gear == ref_dgear) else report_mismatch("depth_gear", depth_gear, ref_dgear);
    endtask

    // Drains searches first, then waits until the pool clear has landed
    task automatic load_gears(input logic w, input logic [1:0] d);
        repeat (2) step();
        cfg_load       = 1'b1;
        cfg_width_gear = w;
        cfg_depth_gear = d;
        if ((1 << w) * (1 << d) <= NUM_PMTS) begin
            ref_wgear = w;
            ref_dgear = d;
            ref_err   = 1'b0;
            for (int a = 0; a < ENTRIES; a++) begin
                ref_valid[a] = 1'b0;
            end
        end else begin
            ref_err = 1'b1;
        end
        // New gears and cfg_error show one cycle after the load
        step();
        check_gears();
        step();
    endtask

    // ========================================
    // Result comparison
    // ========================================

    always @(negedge clk) begin
        if (rst_n) begin
            if (match_valid) begin
                if (exp_due_q.size() == 0) begin
                    report_error("match_valid is high with no search pending");
                end else begin
                    cmp_found = exp_found_q.pop_front();
                    cmp_addr  = exp_addr_q.pop_front();
                    cmp_due   = exp_due_q.pop_front();
                    check_count++;
                    assert (cmp_due == cyc)
                        else report_error("search result arrived in the wrong cycle");
                    assert (match_found == cmp_found)
                        else report_mismatch("match_found", match_found, cmp_found);
                    if (cmp_found) begin
                        assert (match_addr == cmp_addr)
                            else report_mismatch("match_addr", match_addr, cmp_addr);
                    end
                end
            end
            if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
                report_error("match_valid did not rise two cycles after a search");
                void'(exp_found_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        logic [AW-1:0]    wa [24];
        logic [KEY_W-1:0] wd [24];
        logic [KEY_W-1:0] wm [24];
        logic [KEY_W-1:0] key;
        cfg_load       = 1'b0;
        cfg_width_gear = '0;
        cfg_depth_gear = '0;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        wr_mask        = '0;
        search_en      = 1'b0;
        search_key     = '0;
        cyc            = 0;
        err_count      = 0;
        check_count    = 0;
        ref_wgear      = 1'b0;
        ref_dgear      = 2'd0;
        ref_err        = 1'b0;
        for (int a = 0; a < ENTRIES; a++) begin
            ref_valid[a] = 1'b0;
        end
        @(posedge rst_n);
        step();

        // Reset state
        check_gears();
        check_count += 2;
        assert (!match_valid) else report_mismatch("match_valid", match_valid, 0);
        assert (!match_found) else report_mismatch("match_found", match_found, 0);
        do_search(KEY_W'($random(seed)));

        // Gear loads, 2 x 8 PMTs is too many
        load_gears(1'b1, 2'd2);
        load_gears(1'b0, 2'd3);
        load_gears(1'b1, 2'd3);
        load_gears(1'b0, 2'd0);

        // Two PMTs wide, four rows deep
        load_gears(1'b1, 2'd2);
        for (int i = 0; i < 24; i++) begin
            wa[i] = AW'($random(seed) & 63);
            wd[i] = $random(seed);
            wm[i] = ($random(seed) & $random(seed)) | 32'h0001_0001;
            do_write(wa[i], wd[i], wm[i]);
        end
        for (int i = 0; i < 24; i++) begin
            key = (wd[i] & wm[i]) | ($random(seed) & ~wm[i]);
            do_search(key);
            // Upper segment differs in a compared bit
            do_search(key ^ 32'h0001_0000);
        end
        for (int i = 0; i < 16; i++) begin
            do_search($random(seed));
        end

        // One PMT wide, eight rows deep
        load_gears(1'b0, 2'd3);
        for (int r = 0; r < 8; r++) begin
            wa[r] = AW'(r * PMT_DEPTH + ($random(seed) & 15));
            wd[r] = {16'($random(seed)), 16'hA500 + 16'(r)};
            do_write(wa[r], wd[r], '1);
        end
        for (int r = 0; r < 8; r++) begin
            do_search({16'($random(seed)), 16'hA500 + 16'(r)});
        end
        load_gears(1'b0, 2'd0);
        do_write(7'd0, 32'h0000_1234, '1);
        do_write(7'd20, 32'h0000_5678, '1);
        do_write(7'd127, 32'h0000_9abc, '1);
        do_search(32'hffff_1234);
        do_search(32'h0000_5678);
        do_search(32'h0000_9abc);

        // Pipelined searches, write and search together, clear on reload
        load_gears(1'b1, 2'd1);
        for (int i = 0; i < 4; i++) begin
            wa[i] = AW'(i * 8 + 3);
            wd[i] = $random(seed);
            do_write(wa[i], wd[i], '1);
        end
        do_search(wd[0]);
        do_search($random(seed));
        do_search(wd[2]);
        do_search(wd[1]);
        do_search(wd[3]);
        do_search(wd[0] ^ 32'h8000_0000);
        key = $random(seed);
        start_search(key);
        start_write(7'd1, key, '1);
        step();
        do_search(key);
        load_gears(1'b1, 2'd1);
        for (int i = 0; i < 4; i++) begin
            do_search(wd[i]);
        end
        do_search(key);
        do_write(7'd2, key, '1);
        do_search(key);

        while (exp_due_q.size() != 0) begin
            @(posedge clk);
        end
        step();
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/segxbar_pkg.sv
common/pmt_bus_if.sv
crossbar/gear_config.sv
crossbar/xbar_fanout.sv
crossbar/match_combine.sv
pool/pmt_tcam_array.sv
src/seg_tcam_top.sv
bench/tb_clock_gen.sv
bench/tb_seg_tcam.sv
